//--- design/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// instruction word geometry
`define CONV_IRW 31     // bits per slot.
`define CONV_IN 3       // slots per word.

// slot 0 addressing
`define CONV_AW 14      // base address width.

// window walk
`define CONV_WIN 3      // side of the square window.

// input buffering
`define CONV_QDEPTH 4   // words held ahead of the loop.

`endif

//--- design/inst_pkg.sv
`include "conv_cfg.svh"

package inst_pkg;

    localparam int WORD_W = `CONV_IRW * `CONV_IN;
    localparam int OP_W = 7;
    localparam int DIM_W = 7;
    localparam int SPARE_W = `CONV_IRW - 1 - OP_W - `CONV_AW - DIM_W;

    typedef logic [WORD_W-1:0] inst_word_t;     // all three slots.
    typedef logic [`CONV_AW-1:0] base_t;
    typedef logic [DIM_W-1:0] dim_t;
    typedef logic [OP_W-1:0] opcode_t;

    // low slot, read as conv or as fc depending on fc_bit
    typedef union packed {
        struct packed {
            logic [SPARE_W-1:0] spare;
            dim_t dim0;                         // row pitch of the window.
            base_t base;
            opcode_t opcode;
            logic fc_bit;
        } conv;
        struct packed {
            logic [SPARE_W-1:0] spare;
            dim_t ch_cnt;                       // channels of the fc layer.
            base_t base;
            opcode_t opcode;
            logic fc_bit;
        } fc;
    } slot0_u;

endpackage

//--- design/loop_pkg.sv
`include "conv_cfg.svh"

package loop_pkg;

    localparam int STEPS = `CONV_WIN * `CONV_WIN;

    typedef logic [3:0] step_t;

    localparam step_t STEP_LAST = step_t'(STEPS - 1);

    typedef enum logic [1:0] {
        WIN_FIRST,          // base of the instruction.
        WIN_NEXT_COL,       // previous base plus one.
        WIN_NEXT_ROW        // row start plus dim0.
    } step_kind_e;

    // kind of the step that follows cur in a row-major walk
    function automatic step_kind_e next_kind(step_t cur);
        int nxt;
        nxt = int'(cur) + 1;
        if ((nxt % `CONV_WIN) == 0) begin
            return WIN_NEXT_ROW;
        end
        return WIN_NEXT_COL;
    endfunction

endpackage

//--- design/inst_queue.sv
`include "conv_cfg.svh"

module inst_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  inst_pkg::inst_word_t in_inst,
    input  logic                 in_valid,
    output logic                 in_ready,
    output inst_pkg::inst_word_t q_inst,
    output logic                 q_valid,
    input  logic                 q_ready
);

    localparam int DEPTH = `CONV_QDEPTH;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    inst_pkg::inst_word_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr;
    logic          rd;

    function automatic logic [PW-1:0] bump(logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready = (count != CW'(DEPTH));
    assign q_valid  = (count != '0);
    assign q_inst   = mem[rd_ptr];
    assign wr       = in_valid && in_ready;
    assign rd       = q_valid && q_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (rd) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= in_inst;
        end
    end

    // pointers meet only when the queue is empty or full
    a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) == (!q_valid || !in_ready));

endmodule

//--- design/axi_frs.sv
module axi_frs #(
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [DW-1:0] m_data,
    input  logic          m_valid,
    output logic          m_ready,
    output logic [DW-1:0] s_data,
    output logic          s_valid,
    input  logic          s_ready
);

    logic [DW-1:0] skid_data;
    logic          skid_valid;
    logic          out_free;
    logic          take;

    assign m_ready  = !skid_valid;              // registered, no path from s_ready.
    assign out_free = s_ready || !s_valid;
    assign take     = m_valid && m_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            s_valid    <= skid_valid || take;
            skid_valid <= 1'b0;
        end else if (take) begin
            skid_valid <= 1'b1;                 // output stalled, park it.
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                s_data <= skid_data;            // drain skid first.
            end else if (take) begin
                s_data <= m_data;
            end
        end else if (take) begin
            skid_data <= m_data;
        end
    end

    // input side obeys valid/ready while stalled
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- design/conv_inst_loop.sv
`include "conv_cfg.svh"

module conv_inst_loop (
    input  logic                 clk,
    input  logic                 rst_n,
    input  inst_pkg::inst_word_t m_inst,
    input  logic                 m_valid,
    output logic                 m_ready,
    output inst_pkg::inst_word_t s_inst,
    output logic                 s_valid,
    input  logic                 s_ready
);

    localparam int IW = `CONV_IRW * `CONV_IN;

    inst_pkg::inst_word_t word_q;
    inst_pkg::slot0_u     in_slot;
    inst_pkg::slot0_u     cur_slot;
    inst_pkg::slot0_u     out_slot;
    inst_pkg::base_t      base_q;
    inst_pkg::base_t      row_q;
    inst_pkg::base_t      next_base;
    inst_pkg::inst_word_t frs_data;
    loop_pkg::step_t      step_q;
    loop_pkg::step_kind_e kind;
    logic                 busy_q;
    logic                 last;
    logic                 push;
    logic                 load;
    logic                 advance;
    logic                 frs_ready;

    assign in_slot  = m_inst[`CONV_IRW-1:0];
    assign cur_slot = word_q[`CONV_IRW-1:0];

    // fc words end after their single push
    assign last    = busy_q && (cur_slot.conv.fc_bit || step_q == loop_pkg::STEP_LAST);
    assign push    = busy_q && frs_ready;
    assign m_ready = !busy_q || (last && frs_ready);
    assign load    = m_valid && m_ready;
    assign advance = push && !last;

    always_comb begin
        if (load) begin
            kind = loop_pkg::WIN_FIRST;
        end else begin
            kind = loop_pkg::next_kind(step_q);
        end
    end

    always_comb begin
        case (kind)
            loop_pkg::WIN_FIRST:    next_base = in_slot.conv.base;
            loop_pkg::WIN_NEXT_COL: next_base = base_q + inst_pkg::base_t'(1);
            loop_pkg::WIN_NEXT_ROW:
                next_base = row_q + inst_pkg::base_t'(cur_slot.conv.dim0);
            default:                next_base = base_q;
        endcase
    end

    always_comb begin
        out_slot           = cur_slot;
        out_slot.conv.base = base_q;        // same bits back for fc.
    end

    assign frs_data = {word_q[IW-1:`CONV_IRW], out_slot};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            step_q <= '0;
        end else if (load) begin
            busy_q <= 1'b1;
            step_q <= '0;
        end else if (push && last) begin
            busy_q <= 1'b0;
        end else if (advance) begin
            step_q <= step_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= m_inst;
        end
        if (load || advance) begin
            base_q <= next_base;
            if (kind != loop_pkg::WIN_NEXT_COL) begin
                row_q <= next_base;         // new row start.
            end
        end
    end

    axi_frs #(
        .DW(IW)
    ) i_axi_frs (
        .clk    (clk),
        .rst_n  (rst_n),
        .m_data (frs_data),
        .m_valid(busy_q),
        .m_ready(frs_ready),
        .s_data (s_inst),
        .s_valid(s_valid),
        .s_ready(s_ready)
    );

    a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
        step_q <= loop_pkg::STEP_LAST);

endmodule

//--- design/conv_inst_top.sv
module conv_inst_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  inst_pkg::inst_word_t in_inst,
    input  logic                 in_valid,
    output logic                 in_ready,
    output inst_pkg::inst_word_t out_inst,
    output logic                 out_valid,
    input  logic                 out_ready
);

    inst_pkg::inst_word_t q_inst;
    logic                 q_valid;
    logic                 q_ready;

    inst_queue i_inst_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_inst (in_inst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .q_inst  (q_inst),
        .q_valid (q_valid),
        .q_ready (q_ready)
    );

    conv_inst_loop i_conv_inst_loop (
        .clk    (clk),
        .rst_n  (rst_n),
        .m_inst (q_inst),
        .m_valid(q_valid),
        .m_ready(q_ready),
        .s_inst (out_inst),
        .s_valid(out_valid),
        .s_ready(out_ready)
    );

endmodule

//--- sim/tb_conv_inst.sv
`include "conv_cfg.svh"

module tb_conv_inst;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLES_PER_LINE = 40;
    localparam int STALL_CYCLES = 40;    // long enough to fill the queue.

    logic                 clk;
    logic                 rst_n;
    inst_pkg::inst_word_t in_inst;
    logic                 in_valid;
    logic                 in_ready;
    inst_pkg::inst_word_t out_inst;
    logic                 out_valid;
    logic                 out_ready;

    inst_pkg::inst_word_t in_q[$];
    inst_pkg::inst_word_t exp_q[$];
    int                   n_lines;
    int                   n_checks;
    int                   n_errors;
    int                   n_extra;
    int                   n_seen;
    bit                   saw_full;

    conv_inst_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_inst  (in_inst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_inst (out_inst),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(string name, inst_pkg::inst_word_t exp,
                                 inst_pkg::inst_word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // name from the slot 0 view that applies to the word
    function automatic string word_name(inst_pkg::inst_word_t w, int idx);
        inst_pkg::slot0_u s;
        s = w[`CONV_IRW-1:0];
        if (s.fc.fc_bit) begin
            return $sformatf("fc word %0d (ch %0d)", idx, s.fc.ch_cnt);
        end
        return $sformatf("conv word %0d (base %h)", idx, s.conv.base);
    endfunction

    task automatic load_trace(output bit ok);
        int                   fd;
        int                   n;
        string                line;
        logic [7:0]           tag;
        inst_pkg::inst_word_t w;
        ok = 1'b0;
        fd = $fopen("sim/conv_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%c %h", tag, w) == 2) begin
                    if (tag == "I") begin
                        in_q.push_back(w);
                        n_lines++;
                    end else if (tag == "E") begin
                        exp_q.push_back(w);
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        int gap;
        foreach (in_q[i]) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            in_inst  = in_q[i];
            in_valid = 1'b1;
            while (!in_ready) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            in_inst  = '0;
        end
    endtask

    task automatic drive_out_ready();
        out_ready = 1'b0;
        repeat (STALL_CYCLES) @(posedge clk);
        forever begin
            #2;
            out_ready = ($urandom_range(3, 0) != 0);    // ready about 3 of 4 cycles.
            @(posedge clk);
        end
    endtask

    task automatic watch_outputs();
        inst_pkg::inst_word_t exp;
        forever begin
            @(negedge clk);    // handshake settled mid-cycle.
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    n_extra++;
                    $display("output word %h arrived when none was expected", out_inst);
                end else begin
                    exp = exp_q.pop_front();
                    compare_value(word_name(exp, n_seen), exp, out_inst);
                end
                n_seen++;
            end
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, unexpected %0d, missing %0d",
                 n_checks, n_errors, n_extra, exp_q.size());
    endtask

    task automatic watchdog();
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("timeout after %0d cycles with %0d expected words not received",
                 n_lines * CYCLES_PER_LINE, exp_q.size());
        print_counts();
        $display("Some tests failed");
        $finish;
    endtask

    initial begin
        bit ok;
        rst_n     = 1'b0;
        in_inst   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(32'hdb84));
        load_trace(ok);
        if (!ok) begin
            $display("could not open the trace file sim/conv_trace.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            #2;
            rst_n = 1'b1;
            @(negedge clk);
            compare_value("reset out_valid", 1'b0, out_valid);
            compare_value("reset in_ready", 1'b1, in_ready);
            @(posedge clk);
            #2;
            fork
                drive_inputs();
                drive_out_ready();
                watch_outputs();
                watchdog();
            join_none
            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (CYCLES_PER_LINE) @(posedge clk);    // catch late extra words.
            if (!saw_full) begin
                n_errors++;
                $display("in_ready never went low while out_ready was held low");
            end
            print_counts();
            if (n_errors == 0 && n_extra == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

//--- sim/conv_trace.txt
# I <hex>: 93-bit instruction word offered at the input, in order
# E <hex>: 93-bit word expected at the output, in order
I 0123456789abcdef3001232b
E 0123456789abcdef3001232b
I 00000000deadbeef44010044
E 00000000deadbeef44010044
E 00000000deadbeef44010144
E 00000000deadbeef44010244
E 00000000deadbeef44011044
E 00000000deadbeef44011144
E 00000000deadbeef44011244
E 00000000deadbeef44012044
E 00000000deadbeef44012144
E 00000000deadbeef44012244
I 1fedcba987654321fffffefe
E 1fedcba987654321fffffefe
E 1fedcba987654321fffffffe
E 1fedcba987654321ffc000fe
E 1fedcba987654321ffc07dfe
E 1fedcba987654321ffc07efe
E 1fedcba987654321ffc07ffe
E 1fedcba987654321ffc0fcfe
E 1fedcba987654321ffc0fdfe
E 1fedcba987654321ffc0fefe
I 0000000000000001017fff03
E 0000000000000001017fff03
I 0aaaaaaaaaaaaaaa00c00000
E 0aaaaaaaaaaaaaaa00c00000
E 0aaaaaaaaaaaaaaa00c00100
E 0aaaaaaaaaaaaaaa00c00200
E 0aaaaaaaaaaaaaaa00c00300
E 0aaaaaaaaaaaaaaa00c00400
E 0aaaaaaaaaaaaaaa00c00500
E 0aaaaaaaaaaaaaaa00c00600
E 0aaaaaaaaaaaaaaa00c00700
E 0aaaaaaaaaaaaaaa00c00800
I 11111111111111115feaaa81
E 11111111111111115feaaa81

//--- compile.f
+incdir+design
design/inst_pkg.sv
design/loop_pkg.sv
design/inst_queue.sv
design/axi_frs.sv
design/conv_inst_loop.sv
design/conv_inst_top.sv
sim/tb_conv_inst.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds tb_conv_inst with Verilator and runs it from the project root.
# The exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_conv_inst \
    -f compile.f \
    -o tb_conv_inst \
    && ./obj_dir/tb_conv_inst | tee /dev/stderr | grep -qx "All tests passed" \
    && { echo "simulation PASSED"; exit 0; } \
    || { echo "simulation FAILED"; exit 1; }
